//--- vlog.f
verilog/cache_pkg.sv
verilog/cache_bus_if.sv
verilog/frame_ram_if.sv
verilog/frame_ram.sv
verilog/cache_controller.sv
verilog/noncache_router.sv
verilog/direct_mapped_cache.sv
verification/cache_properties.sv
verification/direct_mapped_cache_tb.sv

//--- verification/direct_mapped_cache_tb.sv
// testbench for the direct-mapped cache with a wait-state memory model, reference model and stimulus table
`timescale 1ns/1ps

module direct_mapped_cache_tb;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_FLUSH
    } op_t;

    typedef struct packed {
        op_t                 op;
        cache_pkg::addr_t    addr;
        cache_pkg::word_t    wdata;
        cache_pkg::byte_en_t byte_en;
        logic [3:0]          exp_reads;
        logic [3:0]          exp_writes;
    } row_t;

    logic                CLK;
    logic                nRST;
    logic                flush;
    logic                flush_done;
    cache_pkg::addr_t    proc_addr;
    cache_pkg::word_t    proc_wdata;
    cache_pkg::byte_en_t proc_byte_en;
    logic                proc_ren;
    logic                proc_wen;
    cache_pkg::word_t    proc_rdata;
    logic                proc_busy;
    cache_pkg::addr_t    mem_addr;
    cache_pkg::word_t    mem_wdata;
    cache_pkg::byte_en_t mem_byte_en;
    logic                mem_ren;
    logic                mem_wen;
    cache_pkg::word_t    mem_rdata;
    logic                mem_busy;

    // memory window indexed by address bit 31 and bits 11:2
    cache_pkg::word_t mem_array [0:2047];
    cache_pkg::word_t ref_array [0:2047];
    row_t             rows      [0:16];

    integer seed        = 32'h18aa_24e3;
    int     wait_left   = 0;
    int     mem_reads   = 0;
    int     mem_writes  = 0;
    int     done_pulses = 0;

    direct_mapped_cache direct_mapped_cache_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .flush_done   (flush_done),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy)
    );

    assign mem_rdata = mem_array[{mem_addr[31], mem_addr[11:2]}];

    function automatic logic [10:0] mem_index(input cache_pkg::addr_t a);
        return {a[31], a[11:2]};
    endfunction

    function automatic cache_pkg::word_t fill_pattern(input cache_pkg::addr_t a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    // enabled byte lanes come from the new word
    function automatic cache_pkg::word_t merge_lanes(input cache_pkg::word_t old_word,
                                                     input cache_pkg::word_t new_word,
                                                     input cache_pkg::byte_en_t lanes);
        cache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got %h, expected %h", name, actual, expected);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic load_table();
        // op, address, wdata, byte_en, memory reads, memory writes
        rows[0]  = '{OP_READ,  32'h0000_0010, 32'h0000_0000, 4'hf, 4'd2, 4'd0};
        rows[1]  = '{OP_READ,  32'h0000_0014, 32'h0000_0000, 4'hf, 4'd0, 4'd0};
        rows[2]  = '{OP_WRITE, 32'h0000_0014, 32'hdead_beef, 4'h6, 4'd0, 4'd0};
        rows[3]  = '{OP_READ,  32'h0000_0014, 32'h0000_0000, 4'hf, 4'd0, 4'd0};
        rows[4]  = '{OP_WRITE, 32'h0000_0048, 32'h1234_5678, 4'hf, 4'd2, 4'd0};
        rows[5]  = '{OP_READ,  32'h0000_004c, 32'h0000_0000, 4'hf, 4'd0, 4'd0};
        rows[6]  = '{OP_READ,  32'h0000_0410, 32'h0000_0000, 4'hf, 4'd2, 4'd2};
        rows[7]  = '{OP_READ,  32'h0000_0010, 32'h0000_0000, 4'hf, 4'd2, 4'd0};
        rows[8]  = '{OP_WRITE, 32'h8000_0020, 32'hcafe_f00d, 4'h9, 4'd0, 4'd1};
        rows[9]  = '{OP_READ,  32'h8000_0020, 32'h0000_0000, 4'hf, 4'd1, 4'd0};
        rows[10] = '{OP_READ,  32'h0000_0048, 32'h0000_0000, 4'hf, 4'd0, 4'd0};
        rows[11] = '{OP_WRITE, 32'h0000_0010, 32'h0000_00a5, 4'h1, 4'd0, 4'd0};
        rows[12] = '{OP_FLUSH, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'd0, 4'd4};
        rows[13] = '{OP_READ,  32'h0000_0048, 32'h0000_0000, 4'hf, 4'd2, 4'd0};
        rows[14] = '{OP_READ,  32'h0000_0014, 32'h0000_0000, 4'hf, 4'd2, 4'd0};
        rows[15] = '{OP_WRITE, 32'h0000_0ff8, 32'h0bad_c0de, 4'hc, 4'd2, 4'd0};
        rows[16] = '{OP_READ,  32'h0000_0ff8, 32'h0000_0000, 4'hf, 4'd0, 4'd0};
    endtask

    task automatic init_memory();
        logic [10:0]      idx;
        cache_pkg::addr_t a;
        for (int i = 0; i < $size(mem_array); i++) begin
            idx = i[10:0];
            a = {idx[10], 19'b0, idx[9:0], 2'b00};
            mem_array[i] = fill_pattern(a);
            ref_array[i] = fill_pattern(a);
        end
    endtask

    // hold the request until proc_busy is seen low at a rising edge
    task automatic do_access(input row_t r, output cache_pkg::word_t rdata, output int cycles);
        logic done;
        proc_addr    = r.addr;
        proc_wdata   = r.wdata;
        proc_byte_en = r.byte_en;
        proc_ren     = (r.op == OP_READ);
        proc_wen     = (r.op == OP_WRITE);
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge CLK);
            cycles++;
            done  = !proc_busy;
            rdata = proc_rdata;
        end
        @(negedge CLK);
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    task automatic run_flush();
        int pulses_before;
        pulses_before = done_pulses;
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        while (done_pulses == pulses_before) begin
            @(negedge CLK);
        end
        // a second pulse would show up here
        @(negedge CLK);
        check_value("flush_done pulses", done_pulses - pulses_before, 1);
    endtask

    task automatic compare_memory();
        for (int i = 0; i < $size(mem_array); i++) begin
            check_value("mem_array", mem_array[i], ref_array[i]);
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever begin
            #50 CLK = ~CLK;
        end
    end

    // wait states for the next transfer
    always @(negedge CLK) begin
        mem_busy <= (wait_left != 0);
    end

    always @(posedge CLK) begin : memory_model
        cache_pkg::word_t merged;
        logic [10:0]      idx;
        idx = mem_index(mem_addr);
        if (mem_ren || mem_wen) begin
            if (mem_busy) begin
                wait_left <= wait_left - 1;
            end else begin
                if (proc_addr >= cache_pkg::NONCACHE_START && (proc_ren || proc_wen)) begin
                    check_value("mem_addr", mem_addr, proc_addr);
                    check_value("mem_byte_en", mem_byte_en, proc_byte_en);
                    if (mem_wen) begin
                        check_value("mem_wdata", mem_wdata, proc_wdata);
                    end
                end
                if (mem_wen) begin
                    merged = merge_lanes(mem_array[idx], mem_wdata, mem_byte_en);
                    check_value("mem_wdata merged", merged, ref_array[idx]);
                    mem_array[idx] <= merged;
                    mem_writes     <= mem_writes + 1;
                end else begin
                    mem_reads <= mem_reads + 1;
                end
                wait_left <= $unsigned($random(seed)) % 4;
            end
        end
        if (flush_done) begin
            done_pulses <= done_pulses + 1;
        end
    end

    initial begin : stimulus
        cache_pkg::word_t got;
        int               cycles;
        int               reads_before;
        int               writes_before;
        int               flush_rows;
        nRST         = 1'b0;
        flush        = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        mem_busy     = 1'b0;
        flush_rows   = 0;
        load_table();
        init_memory();
        repeat (10) @(negedge CLK);
        nRST = 1'b1;
        for (int i = 0; i < $size(rows); i++) begin
            reads_before  = mem_reads;
            writes_before = mem_writes;
            if (rows[i].op == OP_FLUSH) begin
                flush_rows++;
                run_flush();
                compare_memory();
            end else begin
                if (rows[i].op == OP_WRITE) begin
                    ref_array[mem_index(rows[i].addr)] =
                        merge_lanes(ref_array[mem_index(rows[i].addr)], rows[i].wdata,
                                    rows[i].byte_en);
                end
                do_access(rows[i], got, cycles);
                if (rows[i].op == OP_READ) begin
                    check_value("proc_rdata", got, ref_array[mem_index(rows[i].addr)]);
                end
                // a cacheable hit takes a RAM read and one evaluate cycle
                if (rows[i].addr < cache_pkg::NONCACHE_START && rows[i].exp_reads == 0 &&
                    rows[i].exp_writes == 0) begin
                    check_value("hit cycles", cycles, 2);
                end
            end
            check_value("mem read count", mem_reads - reads_before, rows[i].exp_reads);
            check_value("mem write count", mem_writes - writes_before, rows[i].exp_writes);
        end
        check_value("flush_done total", done_pulses, flush_rows);
        $display("test passed");
        $finish;
    end

    initial begin : assertion_monitor
        wait (direct_mapped_cache_inst.cache_properties_inst.failures != 0);
        $display("a bus property assertion failed");
        $display("test failed");
        $fatal(1, "assertion failure");
    end

    initial begin : watchdog
        repeat ($size(rows) * 200) @(posedge CLK);
        $display("timeout: no result after %0d clock cycles", $size(rows) * 200);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verification/cache_properties.sv
// cache bus properties for strobe exclusion, flush_done width, quiet reset and address hold
`timescale 1ns/1ps

module cache_properties (
    input logic             CLK,
    input logic             nRST,
    input logic             flush_done,
    input cache_pkg::addr_t mem_addr,
    input logic             mem_ren,
    input logic             mem_wen,
    input logic             mem_busy
);

    // count of failed assertions
    int failures = 0;

    strobes_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else begin
            $error("mem_ren and mem_wen high in the same cycle");
            failures = failures + 1;
        end

    flush_done_single: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else begin
            $error("flush_done high for more than one cycle");
            failures = failures + 1;
        end

    // no memory traffic while reset is held
    reset_quiet: assert property (@(posedge CLK)
        !nRST |-> (!mem_ren && !mem_wen))
        else begin
            $error("memory strobe high during reset");
            failures = failures + 1;
        end

    addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
        ((mem_ren || mem_wen) && mem_busy) |=> $stable(mem_addr))
        else begin
            $error("mem_addr changed while mem_busy was high");
            failures = failures + 1;
        end

endmodule

bind direct_mapped_cache cache_properties cache_properties_inst (
    .CLK        (CLK),
    .nRST       (nRST),
    .flush_done (flush_done),
    .mem_addr   (mem_addr),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .mem_busy   (mem_busy)
);

//--- verilog/direct_mapped_cache.sv
// direct-mapped write-back data cache top level: frame RAM, controller and non-cacheable router
`timescale 1ns/1ps

module direct_mapped_cache (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                flush,
    output logic                flush_done,
    input  cache_pkg::addr_t    proc_addr,
    input  cache_pkg::word_t    proc_wdata,
    input  cache_pkg::byte_en_t proc_byte_en,
    input  logic                proc_ren,
    input  logic                proc_wen,
    output cache_pkg::word_t    proc_rdata,
    output logic                proc_busy,
    output cache_pkg::addr_t    mem_addr,
    output cache_pkg::word_t    mem_wdata,
    output cache_pkg::byte_en_t mem_byte_en,
    output logic                mem_ren,
    output logic                mem_wen,
    input  cache_pkg::word_t    mem_rdata,
    input  logic                mem_busy
);

    logic             direct;
    cache_pkg::word_t cache_rdata;
    logic             cache_busy;

    cache_bus_if ctrl_bus_if ();
    frame_ram_if ram_if ();

    frame_ram frame_ram_inst (
        .CLK (CLK),
        .ram (ram_if.ram)
    );

    cache_controller cache_controller_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .direct       (direct),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .flush_done   (flush_done),
        .cache_rdata  (cache_rdata),
        .cache_busy   (cache_busy),
        .mem_bus      (ctrl_bus_if.ctrl),
        .ram          (ram_if.ctrl)
    );

    noncache_router noncache_router_inst (
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .proc_byte_en (proc_byte_en),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .cache_rdata  (cache_rdata),
        .cache_busy   (cache_busy),
        .direct       (direct),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .ctrl_bus     (ctrl_bus_if.router)
    );

endmodule

//--- verilog/noncache_router.sv
// non-cacheable router: decodes direct addresses and muxes memory between processor and cache
`timescale 1ns/1ps

module noncache_router (
    input  cache_pkg::addr_t    proc_addr,
    input  cache_pkg::word_t    proc_wdata,
    input  cache_pkg::byte_en_t proc_byte_en,
    input  logic                proc_ren,
    input  logic                proc_wen,
    input  cache_pkg::word_t    mem_rdata,
    input  logic                mem_busy,
    input  cache_pkg::word_t    cache_rdata,
    input  logic                cache_busy,
    output logic                direct,
    output cache_pkg::addr_t    mem_addr,
    output cache_pkg::word_t    mem_wdata,
    output cache_pkg::byte_en_t mem_byte_en,
    output logic                mem_ren,
    output logic                mem_wen,
    output cache_pkg::word_t    proc_rdata,
    output logic                proc_busy,
    cache_bus_if.router         ctrl_bus
);

    logic direct_req;

    assign direct     = (proc_addr >= cache_pkg::NONCACHE_START);
    // only an active direct access takes the memory bus
    assign direct_req = direct && (proc_ren || proc_wen);

    assign mem_addr    = direct_req ? proc_addr    : ctrl_bus.addr;
    assign mem_wdata   = direct_req ? proc_wdata   : ctrl_bus.wdata;
    assign mem_byte_en = direct_req ? proc_byte_en : ctrl_bus.byte_en;
    assign mem_ren     = direct_req ? proc_ren     : ctrl_bus.ren;
    assign mem_wen     = direct_req ? proc_wen     : ctrl_bus.wen;

    assign proc_rdata = direct_req ? mem_rdata : cache_rdata;
    assign proc_busy  = direct_req ? mem_busy  : cache_busy;

    // controller stalls while the processor owns memory
    assign ctrl_bus.rdata = mem_rdata;
    assign ctrl_bus.busy  = direct_req ? 1'b1 : mem_busy;

endmodule

//--- verilog/cache_controller.sv
// cache controller: lookup, write merge, write-back, block fill and flush/invalidate FSM
`timescale 1ns/1ps

module cache_controller (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                flush,
    input  logic                direct,
    input  cache_pkg::addr_t    proc_addr,
    input  cache_pkg::word_t    proc_wdata,
    input  cache_pkg::byte_en_t proc_byte_en,
    input  logic                proc_ren,
    input  logic                proc_wen,
    output logic                flush_done,
    output cache_pkg::word_t    cache_rdata,
    output logic                cache_busy,
    cache_bus_if.ctrl           mem_bus,
    frame_ram_if.ctrl           ram
);

    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FETCH,
        FILL,
        FLUSH_READ,
        FLUSH_CHECK,
        FLUSH_WB,
        FLUSH_CLEAR
    } state_t;

    state_t              state, state_next;
    cache_pkg::blk_off_t cnt, cnt_next;
    cache_pkg::idx_t     flush_idx, flush_idx_next;
    logic                init_flag;
    logic                flush_reg;
    logic                pass_done;

    // frame buffer
    cache_pkg::tag_t     fb_tag, fb_tag_next;
    cache_pkg::block_t   fb_block, fb_block_next;
    cache_pkg::block_t   merged_block;

    cache_pkg::tag_t     req_tag;
    cache_pkg::idx_t     req_idx;
    cache_pkg::blk_off_t req_off;
    logic                request;
    logic                tag_match;
    logic                last_word;
    logic                last_idx;

    // byte-lane merge of new data over an old word
    function automatic cache_pkg::word_t merge_word(input cache_pkg::word_t old_word,
                                                    input cache_pkg::word_t new_word,
                                                    input cache_pkg::byte_en_t be);
        cache_pkg::word_t result;
        result = old_word;
        for (int i = 0; i < $bits(cache_pkg::byte_en_t); i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign req_tag = proc_addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
    assign req_idx = proc_addr[cache_pkg::IDX_LSB +: cache_pkg::IDX_W];
    assign req_off = proc_addr[cache_pkg::BYTE_OFF_W +: cache_pkg::BLK_OFF_W];

    assign request   = (proc_ren || proc_wen) && !direct;
    assign tag_match = ram.rvalid && (ram.rtag == req_tag);
    assign last_word = (cnt == cache_pkg::blk_off_t'(cache_pkg::BLOCK_WORDS - 1));
    assign last_idx  = (flush_idx == cache_pkg::idx_t'(cache_pkg::N_INDICES - 1));

    always_comb begin
        state_next      = state;
        cnt_next        = cnt;
        flush_idx_next  = flush_idx;
        fb_tag_next     = fb_tag;
        fb_block_next   = fb_block;
        merged_block    = fb_block;
        pass_done       = 1'b0;
        flush_done      = 1'b0;
        cache_busy      = 1'b1;
        cache_rdata     = ram.rblock[req_off*cache_pkg::WORD_W +: cache_pkg::WORD_W];
        ram.idx         = req_idx;
        ram.ren         = 1'b0;
        ram.wen         = 1'b0;
        ram.wtag        = '0;
        ram.wvalid      = 1'b0;
        ram.wdirty      = 1'b0;
        ram.wblock      = '0;
        mem_bus.addr    = {fb_tag, req_idx, cnt, {cache_pkg::BYTE_OFF_W{1'b0}}};
        mem_bus.wdata   = fb_block[cnt*cache_pkg::WORD_W +: cache_pkg::WORD_W];
        mem_bus.byte_en = '1;
        mem_bus.ren     = 1'b0;
        mem_bus.wen     = 1'b0;

        case (state)
            IDLE: begin
                if (init_flag || flush_reg || flush) begin
                    flush_idx_next = '0;
                    state_next     = FLUSH_READ;
                end else if (request) begin
                    ram.ren    = 1'b1;
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (tag_match) begin
                    cache_busy = 1'b0;
                    state_next = IDLE;
                    if (proc_wen) begin
                        merged_block = ram.rblock;
                        merged_block[req_off*cache_pkg::WORD_W +: cache_pkg::WORD_W] =
                            merge_word(cache_rdata, proc_wdata, proc_byte_en);
                        ram.wen    = 1'b1;
                        ram.wtag   = req_tag;
                        ram.wvalid = 1'b1;
                        ram.wdirty = 1'b1;
                        ram.wblock = merged_block;
                    end
                end else begin
                    // miss, keep the victim for write-back
                    fb_tag_next   = ram.rtag;
                    fb_block_next = ram.rblock;
                    cnt_next      = '0;
                    state_next    = (ram.rvalid && ram.rdirty) ? WRITEBACK : FETCH;
                end
            end
            WRITEBACK: begin
                mem_bus.wen = 1'b1;
                if (!mem_bus.busy) begin
                    cnt_next = cnt + 1'b1;
                    if (last_word) begin
                        cnt_next   = '0;
                        state_next = FETCH;
                    end
                end
            end
            FETCH: begin
                mem_bus.addr = {req_tag, req_idx, cnt, {cache_pkg::BYTE_OFF_W{1'b0}}};
                mem_bus.ren  = 1'b1;
                if (!mem_bus.busy) begin
                    fb_block_next[cnt*cache_pkg::WORD_W +: cache_pkg::WORD_W] = mem_bus.rdata;
                    cnt_next = cnt + 1'b1;
                    if (last_word) begin
                        cnt_next   = '0;
                        state_next = FILL;
                    end
                end
            end
            FILL: begin
                cache_rdata = fb_block[req_off*cache_pkg::WORD_W +: cache_pkg::WORD_W];
                if (proc_wen) begin
                    merged_block[req_off*cache_pkg::WORD_W +: cache_pkg::WORD_W] =
                        merge_word(cache_rdata, proc_wdata, proc_byte_en);
                end
                ram.wen    = 1'b1;
                ram.wtag   = req_tag;
                ram.wvalid = 1'b1;
                ram.wdirty = proc_wen;
                ram.wblock = merged_block;
                cache_busy = 1'b0;
                state_next = IDLE;
            end
            FLUSH_READ: begin
                ram.idx    = flush_idx;
                ram.ren    = 1'b1;
                // nothing is trusted yet during the reset pass
                state_next = init_flag ? FLUSH_CLEAR : FLUSH_CHECK;
            end
            FLUSH_CHECK: begin
                fb_tag_next   = ram.rtag;
                fb_block_next = ram.rblock;
                cnt_next      = '0;
                state_next    = (ram.rvalid && ram.rdirty) ? FLUSH_WB : FLUSH_CLEAR;
            end
            FLUSH_WB: begin
                mem_bus.addr = {fb_tag, flush_idx, cnt, {cache_pkg::BYTE_OFF_W{1'b0}}};
                mem_bus.wen  = 1'b1;
                if (!mem_bus.busy) begin
                    cnt_next = cnt + 1'b1;
                    if (last_word) begin
                        cnt_next   = '0;
                        state_next = FLUSH_CLEAR;
                    end
                end
            end
            FLUSH_CLEAR: begin
                ram.idx = flush_idx;
                ram.wen = 1'b1;
                if (last_idx) begin
                    pass_done  = 1'b1;
                    flush_done = flush_reg && !init_flag;
                    state_next = IDLE;
                end else begin
                    flush_idx_next = flush_idx + 1'b1;
                    state_next     = FLUSH_READ;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            cnt       <= '0;
            flush_idx <= '0;
            init_flag <= 1'b1;
            flush_reg <= 1'b0;
        end else begin
            state     <= state_next;
            cnt       <= cnt_next;
            flush_idx <= flush_idx_next;
            if (pass_done) begin
                init_flag <= 1'b0;
            end
            // a new pulse on the final index starts another pass
            if (flush) begin
                flush_reg <= 1'b1;
            end else if (flush_done) begin
                flush_reg <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        fb_tag   <= fb_tag_next;
        fb_block <= fb_block_next;
    end

endmodule

//--- verilog/frame_ram.sv
// frame RAM: tag, valid, dirty and data block per index, one-cycle synchronous read
`timescale 1ns/1ps

module frame_ram (
    input logic      CLK,
    frame_ram_if.ram ram
);

    cache_pkg::tag_t   tag_mem   [cache_pkg::N_INDICES];
    logic              valid_mem [cache_pkg::N_INDICES];
    logic              dirty_mem [cache_pkg::N_INDICES];
    cache_pkg::block_t block_mem [cache_pkg::N_INDICES];

    // write port
    always_ff @(posedge CLK) begin
        if (ram.wen) begin
            tag_mem[ram.idx]   <= ram.wtag;
            valid_mem[ram.idx] <= ram.wvalid;
            dirty_mem[ram.idx] <= ram.wdirty;
            block_mem[ram.idx] <= ram.wblock;
        end
    end

    // read port, outputs hold until the next ren
    always_ff @(posedge CLK) begin
        if (ram.ren) begin
            ram.rtag   <= tag_mem[ram.idx];
            ram.rvalid <= valid_mem[ram.idx];
            ram.rdirty <= dirty_mem[ram.idx];
            ram.rblock <= block_mem[ram.idx];
        end
    end

endmodule

//--- verilog/frame_ram_if.sv
// frame RAM port: one index, write frame fields and registered read frame fields
`timescale 1ns/1ps

interface frame_ram_if;

    cache_pkg::idx_t   idx;
    logic              ren;
    logic              wen;
    cache_pkg::tag_t   wtag;
    logic              wvalid;
    logic              wdirty;
    cache_pkg::block_t wblock;
    cache_pkg::tag_t   rtag;
    logic              rvalid;
    logic              rdirty;
    cache_pkg::block_t rblock;

    modport ctrl (
        output idx, ren, wen, wtag, wvalid, wdirty, wblock,
        input  rtag, rvalid, rdirty, rblock
    );

    modport ram (
        input  idx, ren, wen, wtag, wvalid, wdirty, wblock,
        output rtag, rvalid, rdirty, rblock
    );

endinterface

//--- verilog/cache_bus_if.sv
// word bus with read/write strobes and a busy level, between cache controller and router
`timescale 1ns/1ps

interface cache_bus_if;

    cache_pkg::addr_t    addr;
    cache_pkg::word_t    wdata;
    cache_pkg::byte_en_t byte_en;
    logic                ren;
    logic                wen;
    cache_pkg::word_t    rdata;
    logic                busy;

    // requester side
    modport ctrl (
        output addr, wdata, byte_en, ren, wen,
        input  rdata, busy
    );

    // memory side, as seen through the router
    modport router (
        input  addr, wdata, byte_en, ren, wen,
        output rdata, busy
    );

endinterface

//--- verilog/cache_pkg.sv
// cache package: geometry constants and vector types for the direct-mapped data cache
package cache_pkg;

    // bus and block geometry
    localparam int WORD_W      = 32;
    localparam int BLOCK_WORDS = 2;
    localparam int N_INDICES   = 16;
    localparam int BYTE_OFF_W  = 2;
    localparam int BLK_OFF_W   = $clog2(BLOCK_WORDS);
    localparam int IDX_W       = $clog2(N_INDICES);
    localparam int TAG_W       = WORD_W - BYTE_OFF_W - BLK_OFF_W - IDX_W;
    localparam int BLOCK_W     = BLOCK_WORDS * WORD_W;

    // field positions inside a byte address
    localparam int IDX_LSB = BYTE_OFF_W + BLK_OFF_W;
    localparam int TAG_LSB = IDX_LSB + IDX_W;

    // everything from here up goes straight to memory
    localparam logic [WORD_W-1:0] NONCACHE_START = 32'h8000_0000;

    typedef logic [WORD_W-1:0] word_t;

    // tag | index | block offset | byte offset
    typedef logic [WORD_W-1:0] addr_t;

    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [IDX_W-1:0]     idx_t;
    typedef logic [BLK_OFF_W-1:0] blk_off_t;
    typedef logic [WORD_W/8-1:0]  byte_en_t;

    // word 0 sits in the low bits
    typedef logic [BLOCK_W-1:0] block_t;

endpackage
